// ==== soc_lite_settings.svh ====
`ifndef SOC_LITE_SETTINGS_SVH
`define SOC_LITE_SETTINGS_SVH

// word bus
`define SOC_ADDR_W        32
`define SOC_DATA_W        32
`define SOC_STRB_W        4

// pin groups
`define GENIO_W           30
`define SAO_W             6
`define PMOD_W            8
`define BTN_W             8
`define LED_REG_W         16
`define LED_PIN_W         9

// region code in addr[31:28]
`define REGION_MISC       4'h2

// misc register index, taken from addr[6:2]
`define REG_IDX_W         5
`define REG_LED           5'd0
`define REG_BTN           5'd1
`define REG_SOC_VER       5'd2
`define REG_CPU_NO        5'd3
`define REG_FLASH_SEL     5'd11
`define REG_GENIO_IN      5'd14
`define REG_GENIO_OUT     5'd15
`define REG_GENIO_OE      5'd16
`define REG_GENIO_W2S     5'd17
`define REG_GENIO_W2C     5'd18
`define REG_GPEXT_IN      5'd19
`define REG_GPEXT_OUT     5'd20
`define REG_GPEXT_OE      5'd21
`define REG_GPEXT_W2S     5'd22
`define REG_GPEXT_W2C     5'd23

// fixed values
`define BUS_ERR_WORD      32'hDEADBEEF
`define RELOAD_MAGIC      24'hD0F1A5
`define SOC_VERSION       32'h0000_8000
`define FSEL_DELAY_START  3'd7
`define DBG_FIFO_ABITS    5

`endif

// ==== soc_lite_pkg.sv ====
`default_nettype none

`include "soc_lite_settings.svh"

package soc_lite_pkg;

	// layout shared by the GPEXT in, out, oe, set and clear registers
	typedef struct packed {
		logic               vdet;
		logic               irda_sd;
		logic [5:0]         pad_hi;
		logic [`PMOD_W-1:0] pmod;
		logic [1:0]         pad_mid;
		logic [`SAO_W-1:0]  sao2;
		logic [1:0]         pad_lo;
		logic [`SAO_W-1:0]  sao1;
	} gpext_fields_t;

	typedef union packed {
		logic [`SOC_DATA_W-1:0] raw;
		gpext_fields_t          f;
	} gpext_word_u;

	// flash select word, upper 24 bits arm the reload
	typedef struct packed {
		logic [23:0] magic;
		logic [6:0]  spare;
		logic        fsel;
	} fsel_fields_t;

	typedef union packed {
		logic [`SOC_DATA_W-1:0] raw;
		fsel_fields_t           f;
	} fsel_word_u;

endpackage

`default_nettype wire

// ==== soc_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_lite_settings.svh"

// single-word bus, valid and payload stay up until ready is seen at an edge
interface soc_bus_if;
	logic [`SOC_ADDR_W-1:0] addr;
	logic [`SOC_DATA_W-1:0] wdata;
	// all zero means a read
	logic [`SOC_STRB_W-1:0] wstrb;
	logic                   valid;
	logic                   ready;
	logic [`SOC_DATA_W-1:0] rdata;

	modport master (
		output addr,
		output wdata,
		output wstrb,
		output valid,
		input  ready,
		input  rdata
	);

	modport slave (
		input  addr,
		input  wdata,
		input  wstrb,
		input  valid,
		output ready,
		output rdata
	);
endinterface

`default_nettype wire

// ==== dbg_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_lite_settings.svh"

module dbg_bridge #(
	parameter int FIFO_ABITS = `DBG_FIFO_ABITS
) (
	input  wire                   clk48m,
	input  wire                   rst,
	input  wire [`SOC_DATA_W-1:0] dbgreg_in,
	input  wire                   dbgreg_sel,
	input  wire                   dbgreg_strobe,
	soc_bus_if.master             bus
);

	localparam int DEPTH = 1 << FIFO_ABITS;
	localparam logic [`SOC_ADDR_W-1:0] ADDR_STEP = 4;

	// entry is {sel, word}, sel set means the word is a new address
	logic [`SOC_DATA_W:0]   fifo_mem [0:DEPTH-1];
	logic [FIFO_ABITS-1:0]  wr_ptr;
	logic [FIFO_ABITS-1:0]  wr_ptr_nxt;
	logic [FIFO_ABITS-1:0]  rd_ptr;
	logic                   fifo_empty;
	logic                   fifo_full;
	logic [`SOC_DATA_W:0]   head;
	logic                   pop;
	logic [`SOC_ADDR_W-1:0] wr_addr;
	logic [`SOC_DATA_W-1:0] wr_data;
	logic                   wr_valid;

	assign wr_ptr_nxt = wr_ptr + 1'b1;
	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_full  = (wr_ptr_nxt == rd_ptr);
	assign head       = fifo_mem[rd_ptr];
	// strobe cycles hold off the pop so the host side never waits
	assign pop        = !dbgreg_strobe && !wr_valid && !fifo_empty;

	assign bus.addr  = wr_addr;
	assign bus.wdata = wr_data;
	assign bus.wstrb = {`SOC_STRB_W{1'b1}};
	assign bus.valid = wr_valid;

	always_ff @(posedge clk48m) begin
		if (dbgreg_strobe) begin
			fifo_mem[wr_ptr] <= {dbgreg_sel, dbgreg_in};
		end
		if (pop && !head[`SOC_DATA_W]) begin
			wr_data <= head[`SOC_DATA_W-1:0];
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			wr_addr  <= '0;
			wr_valid <= 1'b0;
		end else begin
			if (dbgreg_strobe) begin
				wr_ptr <= wr_ptr_nxt;
			end
			if (wr_valid && bus.ready) begin
				wr_valid <= 1'b0;
				wr_addr  <= wr_addr + ADDR_STEP;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				if (head[`SOC_DATA_W]) begin
					wr_addr <= head[`SOC_ADDR_W-1:0];
				end else begin
					wr_valid <= 1'b1;
				end
			end
		end
	end

	// the debug port has no back-pressure, the host must pace itself
	a_no_overrun: assert property (@(posedge clk48m) disable iff (rst)
		dbgreg_strobe |-> !fifo_full)
		else $error("debug FIFO overrun");

endmodule

`default_nettype wire

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  wire       clk48m,
	input  wire       rst,
	soc_bus_if.slave  m0,
	soc_bus_if.slave  m1,
	soc_bus_if.master s,
	output logic      curr_master
);

	logic busy;
	// index of the master that owns the bus, kept after release
	logic grant;

	assign curr_master = grant;

	// fixed priority, master 0 wins when both ask
	always_ff @(posedge clk48m) begin
		if (rst) begin
			busy  <= 1'b0;
			grant <= 1'b0;
		end else if (!busy) begin
			if (m0.valid) begin
				busy  <= 1'b1;
				grant <= 1'b0;
			end else if (m1.valid) begin
				busy  <= 1'b1;
				grant <= 1'b1;
			end
		end else if (s.ready) begin
			// one transfer per grant
			busy <= 1'b0;
		end
	end

	assign s.addr  = grant ? m1.addr : m0.addr;
	assign s.wdata = grant ? m1.wdata : m0.wdata;
	assign s.wstrb = grant ? m1.wstrb : m0.wstrb;
	assign s.valid = busy && (grant ? m1.valid : m0.valid);

	assign m0.ready = busy && !grant && s.ready;
	assign m1.ready = busy && grant && s.ready;
	assign m0.rdata = (busy && !grant) ? s.rdata : '0;
	assign m1.rdata = (busy && grant) ? s.rdata : '0;

	// a completion only goes back to the master whose request is on the bus
	a_ready_m0: assert property (@(posedge clk48m) disable iff (rst)
		m0.ready |-> m0.valid)
		else $error("ready returned to master 0 without a request");

	a_ready_m1: assert property (@(posedge clk48m) disable iff (rst)
		m1.ready |-> m1.valid)
		else $error("ready returned to master 1 without a request");

endmodule

`default_nettype wire

// ==== addr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_lite_settings.svh"

module addr_decoder (
	input  wire       clk48m,
	input  wire       rst,
	soc_bus_if.slave  up,
	soc_bus_if.master misc,
	output logic      bus_error_irq
);

	logic misc_sel;
	logic bus_err;

	assign misc_sel = (up.addr[`SOC_ADDR_W-1 -: 4] == `REGION_MISC);
	// unmapped regions complete at once with the error word
	assign bus_err  = up.valid && !misc_sel;

	assign misc.addr  = up.addr;
	assign misc.wdata = up.wdata;
	assign misc.wstrb = up.wstrb;
	assign misc.valid = up.valid && misc_sel;

	assign up.ready = misc_sel ? misc.ready : bus_err;
	assign up.rdata = misc_sel ? misc.rdata : `BUS_ERR_WORD;

	// the grant drops after the error edge, so this stays a single pulse
	always_ff @(posedge clk48m) begin
		if (rst) begin
			bus_error_irq <= 1'b0;
		end else begin
			bus_error_irq <= bus_err;
		end
	end

	a_misc_ready_sel: assert property (@(posedge clk48m) disable iff (rst)
		misc.ready |-> (misc_sel && up.valid))
		else $error("misc block ready while not selected");

endmodule

`default_nettype wire

// ==== misc_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_lite_settings.svh"

module misc_regs (
	input  wire                     clk48m,
	input  wire                     rst,
	soc_bus_if.slave                bus,
	input  wire                     curr_master,
	input  wire  [`BTN_W-1:0]       btn,
	input  wire  [`GENIO_W-1:0]     genio_in,
	input  wire  [`SAO_W-1:0]       sao1_in,
	input  wire  [`SAO_W-1:0]       sao2_in,
	input  wire  [`PMOD_W-1:0]      pmod_in,
	input  wire                     usb_vdet,
	output logic [`LED_PIN_W-1:0]   led,
	output logic [`GENIO_W-1:0]     genio_out,
	output logic [`GENIO_W-1:0]     genio_oe,
	output logic [`SAO_W-1:0]       sao1_out,
	output logic [`SAO_W-1:0]       sao1_oe,
	output logic [`SAO_W-1:0]       sao2_out,
	output logic [`SAO_W-1:0]       sao2_oe,
	output logic [`PMOD_W-1:0]      pmod_out,
	output logic [`PMOD_W-1:0]      pmod_oe,
	output logic                    irda_sd,
	output logic                    fsel_d,
	output logic                    fsel_strobe,
	output logic                    reload_req
);

	import soc_lite_pkg::*;

	logic [`REG_IDX_W-1:0] idx;
	logic                  wr_en;
	logic [`LED_REG_W-1:0] led_reg;
	gpext_word_u           wr_gp;
	fsel_word_u            wr_fs;
	gpext_word_u           gp_in;
	gpext_word_u           gp_out;
	gpext_word_u           gp_oe;

	assign idx   = bus.addr[6:2];
	assign wr_en = bus.valid && bus.wstrb[0];
	// every access completes in the cycle it is presented
	assign bus.ready = bus.valid;
	assign led = led_reg[`LED_PIN_W-1:0];

	always_comb begin
		wr_gp.raw = bus.wdata;
		wr_fs.raw = bus.wdata;
		gp_in = '0;
		gp_in.f.vdet = usb_vdet;
		gp_in.f.pmod = pmod_in;
		gp_in.f.sao2 = sao2_in;
		gp_in.f.sao1 = sao1_in;
		gp_out = '0;
		gp_out.f.irda_sd = irda_sd;
		gp_out.f.pmod = pmod_out;
		gp_out.f.sao2 = sao2_out;
		gp_out.f.sao1 = sao1_out;
		gp_oe = '0;
		gp_oe.f.pmod = pmod_oe;
		gp_oe.f.sao2 = sao2_oe;
		gp_oe.f.sao1 = sao1_oe;
	end

	// readback, buttons are active low on the board
	always_comb begin
		case (idx)
			`REG_LED:       bus.rdata = {{(`SOC_DATA_W-`LED_REG_W){1'b0}}, led_reg};
			`REG_BTN:       bus.rdata = {{(`SOC_DATA_W-`BTN_W){1'b0}}, ~btn};
			`REG_SOC_VER:   bus.rdata = `SOC_VERSION;
			`REG_CPU_NO:    bus.rdata = {{(`SOC_DATA_W-1){1'b0}}, curr_master};
			`REG_FLASH_SEL: bus.rdata = {{(`SOC_DATA_W-1){1'b0}}, fsel_d};
			`REG_GENIO_IN:  bus.rdata = {{(`SOC_DATA_W-`GENIO_W){1'b0}}, genio_in};
			`REG_GENIO_OUT: bus.rdata = {{(`SOC_DATA_W-`GENIO_W){1'b0}}, genio_out};
			`REG_GENIO_OE:  bus.rdata = {{(`SOC_DATA_W-`GENIO_W){1'b0}}, genio_oe};
			`REG_GPEXT_IN:  bus.rdata = gp_in.raw;
			`REG_GPEXT_OUT: bus.rdata = gp_out.raw;
			`REG_GPEXT_OE:  bus.rdata = gp_oe.raw;
			default:        bus.rdata = '0;
		endcase
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_reg     <= '0;
			genio_out   <= '0;
			genio_oe    <= '0;
			sao1_out    <= '0;
			sao1_oe     <= '0;
			sao2_out    <= '0;
			sao2_oe     <= '0;
			pmod_out    <= '0;
			pmod_oe     <= '0;
			irda_sd     <= 1'b1;
			fsel_d      <= 1'b0;
			fsel_strobe <= 1'b0;
			reload_req  <= 1'b0;
		end else begin
			fsel_strobe <= 1'b0;
			if (wr_en) begin
				case (idx)
					`REG_LED:       led_reg <= bus.wdata[`LED_REG_W-1:0];
					`REG_FLASH_SEL: begin
						fsel_d      <= wr_fs.f.fsel;
						fsel_strobe <= 1'b1;
						// reload stays armed until reset
						if (wr_fs.f.magic == `RELOAD_MAGIC) begin
							reload_req <= 1'b1;
						end
					end
					`REG_GENIO_OUT: genio_out <= bus.wdata[`GENIO_W-1:0];
					`REG_GENIO_OE:  genio_oe <= bus.wdata[`GENIO_W-1:0];
					`REG_GENIO_W2S: genio_out <= genio_out | bus.wdata[`GENIO_W-1:0];
					`REG_GENIO_W2C: genio_out <= genio_out & ~bus.wdata[`GENIO_W-1:0];
					`REG_GPEXT_OUT: begin
						irda_sd  <= wr_gp.f.irda_sd;
						pmod_out <= wr_gp.f.pmod;
						sao2_out <= wr_gp.f.sao2;
						sao1_out <= wr_gp.f.sao1;
					end
					`REG_GPEXT_OE: begin
						pmod_oe <= wr_gp.f.pmod;
						sao2_oe <= wr_gp.f.sao2;
						sao1_oe <= wr_gp.f.sao1;
					end
					`REG_GPEXT_W2S: begin
						irda_sd  <= irda_sd | wr_gp.f.irda_sd;
						pmod_out <= pmod_out | wr_gp.f.pmod;
						sao2_out <= sao2_out | wr_gp.f.sao2;
						sao1_out <= sao1_out | wr_gp.f.sao1;
					end
					`REG_GPEXT_W2C: begin
						irda_sd  <= irda_sd & ~wr_gp.f.irda_sd;
						pmod_out <= pmod_out & ~wr_gp.f.pmod;
						sao2_out <= sao2_out & ~wr_gp.f.sao2;
						sao1_out <= sao1_out & ~wr_gp.f.sao1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== flash_reload.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_lite_settings.svh"

module flash_reload (
	input  wire  clk48m,
	input  wire  rst,
	input  wire  fsel_strobe,
	input  wire  reload_req,
	output logic fsel_c,
	output logic programn
);

	logic [2:0] fsel_delay;
	logic       fpga_reload;

	// fsel_d settles before the clock window, which closes before programn drops
	assign fsel_c   = (fsel_delay == 3'd5) || (fsel_delay == 3'd4) || (fsel_delay == 3'd3);
	assign programn = !fpga_reload;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_delay  <= '0;
			fpga_reload <= 1'b0;
		end else if (fsel_strobe) begin
			fsel_delay <= `FSEL_DELAY_START;
		end else if (fsel_delay != '0) begin
			fsel_delay <= fsel_delay - 1'b1;
			if (fsel_delay == 3'd1 && reload_req) begin
				fpga_reload <= 1'b1;
			end
		end
	end

	// one strobe per flash select write, a longer one would stretch the window
	a_strobe_pulse: assert property (@(posedge clk48m) disable iff (rst)
		fsel_strobe |=> !fsel_strobe)
		else $error("flash select strobe held for more than one cycle");

endmodule

`default_nettype wire

// ==== soc_lite_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_lite_settings.svh"

module soc_lite_top (
	input  wire                     clk48m,
	input  wire                     rst,
	input  wire  [`SOC_ADDR_W-1:0]  bus_addr,
	input  wire  [`SOC_DATA_W-1:0]  bus_wdata,
	input  wire  [`SOC_STRB_W-1:0]  bus_wstrb,
	input  wire                     bus_valid,
	output logic                    bus_ready,
	output logic [`SOC_DATA_W-1:0]  bus_rdata,
	output logic                    bus_error_irq,
	input  wire  [`SOC_DATA_W-1:0]  dbgreg_in,
	input  wire                     dbgreg_sel,
	input  wire                     dbgreg_strobe,
	input  wire  [`BTN_W-1:0]       btn,
	input  wire  [`GENIO_W-1:0]     genio_in,
	input  wire  [`SAO_W-1:0]       sao1_in,
	input  wire  [`SAO_W-1:0]       sao2_in,
	input  wire  [`PMOD_W-1:0]      pmod_in,
	input  wire                     usb_vdet,
	output logic [`LED_PIN_W-1:0]   led,
	output logic [`GENIO_W-1:0]     genio_out,
	output logic [`GENIO_W-1:0]     genio_oe,
	output logic [`SAO_W-1:0]       sao1_out,
	output logic [`SAO_W-1:0]       sao1_oe,
	output logic [`SAO_W-1:0]       sao2_out,
	output logic [`SAO_W-1:0]       sao2_oe,
	output logic [`PMOD_W-1:0]      pmod_out,
	output logic [`PMOD_W-1:0]      pmod_oe,
	output logic                    irda_sd,
	output logic                    fsel_d,
	output logic                    fsel_c,
	output logic                    programn
);

	logic curr_master;
	logic fsel_strobe;
	logic reload_req;

	soc_bus_if ext_bus ();
	soc_bus_if dbg_bus ();
	soc_bus_if arb_bus ();
	soc_bus_if misc_bus ();

	// external master takes arbiter port 0
	assign ext_bus.addr  = bus_addr;
	assign ext_bus.wdata = bus_wdata;
	assign ext_bus.wstrb = bus_wstrb;
	assign ext_bus.valid = bus_valid;
	assign bus_ready     = ext_bus.ready;
	assign bus_rdata     = ext_bus.rdata;

	dbg_bridge dbg (.*, .bus(dbg_bus.master));

	bus_arbiter arb (.*, .m0(ext_bus.slave), .m1(dbg_bus.slave), .s(arb_bus.master));

	addr_decoder dec (.*, .up(arb_bus.slave), .misc(misc_bus.master));

	misc_regs misc (.*, .bus(misc_bus.slave));

	flash_reload reload (.*);

endmodule

`default_nettype wire

// ==== tb_soc_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_lite_settings.svh"

module tb_soc_lite;

	import soc_lite_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int N_RAND = 40;
	localparam int N_IN = 4;
	localparam int N_ERR = 3;
	localparam int XFER_MAX = 8;
	localparam int DBG_WAIT = 40;
	localparam int FSEL_WATCH = 14;
	// transfers of all tests times their worst case, plus the waits that are not transfers
	localparam int WATCHDOG_CYCLES = (N_RAND * 5 + N_IN * 7 + N_ERR + 12) * XFER_MAX
		+ N_ERR + DBG_WAIT + 8 + 2 * FSEL_WATCH + 20;
	localparam logic [31:0] MISC_BASE = 32'h2000_0000;

	logic clk48m, rst;
	logic [31:0] bus_addr, bus_wdata, bus_rdata, dbgreg_in;
	logic [3:0] bus_wstrb;
	logic bus_valid, bus_ready, bus_error_irq, dbgreg_sel, dbgreg_strobe, usb_vdet;
	logic [`BTN_W-1:0] btn;
	logic [`GENIO_W-1:0] genio_in, genio_out, genio_oe;
	logic [`SAO_W-1:0] sao1_in, sao2_in, sao1_out, sao1_oe, sao2_out, sao2_oe;
	logic [`PMOD_W-1:0] pmod_in, pmod_out, pmod_oe;
	logic [`LED_PIN_W-1:0] led;
	logic irda_sd, fsel_d, fsel_c, programn;

	// shadow copies of the register block
	logic [`LED_REG_W-1:0] led_m;
	logic [`GENIO_W-1:0] genio_out_m, genio_oe_m;
	gpext_word_u gp_out_m, gp_oe_m, out_mask, oe_mask;
	logic fsel_d_m;
	logic [31:0] lfsr;
	int fail_count;

	soc_lite_top UUT (.*);

	always #(CLK_PERIOD / 2) clk48m = ~clk48m;

	// galois LFSR, one step per bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
		end
		return val;
	endfunction

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			fail_count++;
			abort_run();
		end
	endtask

	// called on a falling edge, returns on the falling edge after the transfer edge
	task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] wstrb, output logic [31:0] rdata);
		int cycles;
		cycles = 0;
		bus_addr = addr;
		bus_wdata = wdata;
		bus_wstrb = wstrb;
		bus_valid = 1'b1;
		do begin
			@(negedge clk48m);
			cycles++;
			assert (cycles <= XFER_MAX) else begin
				$display("bus transfer to %h got no ready within %0d cycles", addr, XFER_MAX);
				abort_run();
			end
		end while (!bus_ready);
		rdata = bus_rdata;
		@(negedge clk48m);
		bus_valid = 1'b0;
		bus_wstrb = '0;
	endtask

	task automatic write_reg(input logic [4:0] idx, input logic [31:0] data);
		logic [31:0] rd;
		bus_xfer(MISC_BASE | {25'd0, idx, 2'b00}, data, 4'hF, rd);
	endtask

	task automatic read_check(input string name, input logic [4:0] idx, input logic [31:0] exp);
		logic [31:0] rd;
		bus_xfer(MISC_BASE | {25'd0, idx, 2'b00}, '0, 4'h0, rd);
		check_eq(name, exp, rd);
	endtask

	// register rules: plain write, set bits, clear bits
	task automatic apply_write(input logic [4:0] idx, input logic [31:0] data);
		fsel_word_u fw;
		fw.raw = data;
		case (idx)
			`REG_LED:       led_m = data[`LED_REG_W-1:0];
			`REG_FLASH_SEL: fsel_d_m = fw.f.fsel;
			`REG_GENIO_OUT: genio_out_m = data[`GENIO_W-1:0];
			`REG_GENIO_OE:  genio_oe_m = data[`GENIO_W-1:0];
			`REG_GENIO_W2S: genio_out_m = genio_out_m | data[`GENIO_W-1:0];
			`REG_GENIO_W2C: genio_out_m = genio_out_m & ~data[`GENIO_W-1:0];
			`REG_GPEXT_OUT: gp_out_m.raw = data & out_mask.raw;
			`REG_GPEXT_OE:  gp_oe_m.raw = data & oe_mask.raw;
			`REG_GPEXT_W2S: gp_out_m.raw = gp_out_m.raw | (data & out_mask.raw);
			`REG_GPEXT_W2C: gp_out_m.raw = gp_out_m.raw & ~data;
			default: ;
		endcase
	endtask

	task automatic check_pins(input string name);
		gpext_word_u act_out, act_oe;
		act_out.raw = '0;
		act_out.f.irda_sd = irda_sd;
		act_out.f.pmod = pmod_out;
		act_out.f.sao2 = sao2_out;
		act_out.f.sao1 = sao1_out;
		act_oe.raw = '0;
		act_oe.f.pmod = pmod_oe;
		act_oe.f.sao2 = sao2_oe;
		act_oe.f.sao1 = sao1_oe;
		check_eq({name, " led"}, 32'(led_m[`LED_PIN_W-1:0]), 32'(led));
		check_eq({name, " genio_out"}, 32'(genio_out_m), 32'(genio_out));
		check_eq({name, " genio_oe"}, 32'(genio_oe_m), 32'(genio_oe));
		check_eq({name, " gpext out pins"}, gp_out_m.raw, act_out.raw);
		check_eq({name, " gpext oe pins"}, gp_oe_m.raw, act_oe.raw);
		check_eq({name, " fsel_d"}, 32'(fsel_d_m), 32'(fsel_d));
	endtask

	// fsel_c must be one 3-cycle pulse, programn may only fall after it
	task automatic watch_fsel(input string name, input logic expect_reload);
		int high_cnt;
		logic ended;
		high_cnt = 0;
		ended = 1'b0;
		repeat (FSEL_WATCH) begin
			@(negedge clk48m);
			if (fsel_c) begin
				assert (!ended) else begin
					$display("%s: fsel_c rose a second time", name);
					abort_run();
				end
				high_cnt++;
			end else if (high_cnt > 0) begin
				ended = 1'b1;
			end
			if (!programn) begin
				assert (ended) else begin
					$display("%s: programn fell before the fsel_c pulse was over", name);
					abort_run();
				end
			end
		end
		check_eq({name, " fsel_c cycles"}, 32'd3, 32'(high_cnt));
		check_eq({name, " programn"}, expect_reload ? 32'd0 : 32'd1, 32'(programn));
	endtask

	task automatic dbg_push(input logic sel, input logic [31:0] word);
		dbgreg_sel = sel;
		dbgreg_in = word;
		dbgreg_strobe = 1'b1;
		@(negedge clk48m);
		dbgreg_strobe = 1'b0;
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin
		logic [31:0] data, rd;
		logic [4:0] wr_idx;
		logic [3:0] region;
		gpext_word_u gp_exp;
		fsel_word_u fw;
		int cycles;
		clk48m = 1'b0;
		rst = 1'b1;
		bus_addr = '0;
		bus_wdata = '0;
		bus_wstrb = '0;
		bus_valid = 1'b0;
		dbgreg_in = '0;
		dbgreg_sel = 1'b0;
		dbgreg_strobe = 1'b0;
		btn = '0;
		genio_in = '0;
		sao1_in = '0;
		sao2_in = '0;
		pmod_in = '0;
		usb_vdet = 1'b0;
		lfsr = 32'd41;
		fail_count = 0;
		out_mask.raw = '0;
		out_mask.f.irda_sd = 1'b1;
		out_mask.f.pmod = '1;
		out_mask.f.sao2 = '1;
		out_mask.f.sao1 = '1;
		oe_mask = out_mask;
		oe_mask.f.irda_sd = 1'b0;
		led_m = '0;
		genio_out_m = '0;
		genio_oe_m = '0;
		gp_out_m.raw = '0;
		gp_out_m.f.irda_sd = 1'b1;
		gp_oe_m.raw = '0;
		fsel_d_m = 1'b0;
		repeat (2) @(posedge clk48m);
		@(negedge clk48m);
		rst = 1'b0;

		check_eq("reset bus_ready", 32'd0, 32'(bus_ready));
		check_eq("reset bus_error_irq", 32'd0, 32'(bus_error_irq));
		check_eq("reset fsel_c", 32'd0, 32'(fsel_c));
		check_eq("reset programn", 32'd1, 32'(programn));
		check_pins("reset");

		// random writes to the GENIO and GPEXT output registers
		for (int i = 0; i < N_RAND; i++) begin
			data = take_bits(3);
			wr_idx = data[2] ? (`REG_GPEXT_OUT + data[1:0]) : (`REG_GENIO_OUT + data[1:0]);
			data = take_bits(32);
			write_reg(wr_idx, data);
			apply_write(wr_idx, data);
			check_pins("random write");
			read_check("genio_out readback", `REG_GENIO_OUT, 32'(genio_out_m));
			read_check("genio_oe readback", `REG_GENIO_OE, 32'(genio_oe_m));
			read_check("gpext_out readback", `REG_GPEXT_OUT, gp_out_m.raw);
			read_check("gpext_oe readback", `REG_GPEXT_OE, gp_oe_m.raw);
		end

		for (int i = 0; i < N_IN; i++) begin
			data = take_bits(`BTN_W);
			btn = data[`BTN_W-1:0];
			data = take_bits(`GENIO_W);
			genio_in = data[`GENIO_W-1:0];
			data = take_bits(2 * `SAO_W + `PMOD_W + 1);
			{usb_vdet, pmod_in, sao2_in, sao1_in} = data[2*`SAO_W+`PMOD_W:0];
			gp_exp.raw = '0;
			gp_exp.f.vdet = usb_vdet;
			gp_exp.f.pmod = pmod_in;
			gp_exp.f.sao2 = sao2_in;
			gp_exp.f.sao1 = sao1_in;
			read_check("btn readback", `REG_BTN, 32'(btn) ^ ((32'd1 << `BTN_W) - 32'd1));
			read_check("genio_in readback", `REG_GENIO_IN, 32'(genio_in));
			read_check("gpext_in readback", `REG_GPEXT_IN, gp_exp.raw);
			read_check("soc version", `REG_SOC_VER, `SOC_VERSION);
			read_check("master index", `REG_CPU_NO, 32'd0);
			read_check("unlisted index", 5'd7, 32'd0);
			read_check("led readback", `REG_LED, 32'(led_m));
		end

		for (int i = 0; i < N_ERR; i++) begin
			data = take_bits(30);
			region = data[29:26];
			if (region == `REGION_MISC) begin
				region = 4'h9;
			end
			check_eq("bus error irq idle", 32'd0, 32'(bus_error_irq));
			bus_xfer({region, data[25:0], 2'b00}, '0, 4'h0, rd);
			check_eq("bus error rdata", `BUS_ERR_WORD, rd);
			check_eq("bus error irq pulse", 32'd1, 32'(bus_error_irq));
			@(negedge clk48m);
			check_eq("bus error irq end", 32'd0, 32'(bus_error_irq));
		end

		// one write to LED, then a burst from GENIO_OUT over the next three indices
		dbg_push(1'b1, MISC_BASE | {25'd0, `REG_LED, 2'b00});
		data = take_bits(`LED_REG_W);
		dbg_push(1'b0, data);
		apply_write(`REG_LED, data);
		dbg_push(1'b1, MISC_BASE | {25'd0, `REG_GENIO_OUT, 2'b00});
		for (int k = 0; k < 4; k++) begin
			data = take_bits(32);
			dbg_push(1'b0, data);
			apply_write(`REG_GENIO_OUT + k[4:0], data);
		end
		cycles = 0;
		while ((led !== led_m[`LED_PIN_W-1:0] || genio_out !== genio_out_m
			|| genio_oe !== genio_oe_m) && cycles < DBG_WAIT) begin
			@(negedge clk48m);
			cycles++;
		end
		check_pins("debug bridge");
		read_check("debug led readback", `REG_LED, 32'(led_m));

		fw.raw = take_bits(32);
		fw.f.fsel = 1'b1;
		if (fw.f.magic == `RELOAD_MAGIC) begin
			fw.f.magic[0] = ~fw.f.magic[0];
		end
		write_reg(`REG_FLASH_SEL, fw.raw);
		apply_write(`REG_FLASH_SEL, fw.raw);
		watch_fsel("flash select", 1'b0);
		check_pins("flash select");
		read_check("flash select readback", `REG_FLASH_SEL, 32'(fsel_d_m));

		fw.raw = take_bits(32);
		fw.f.magic = `RELOAD_MAGIC;
		fw.f.fsel = 1'b0;
		write_reg(`REG_FLASH_SEL, fw.raw);
		apply_write(`REG_FLASH_SEL, fw.raw);
		watch_fsel("reload", 1'b1);
		check_pins("reload");

		if (fail_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire

// ==== soc_lite.f ====
+incdir+.
soc_lite_pkg.sv
soc_bus_if.sv
dbg_bridge.sv
bus_arbiter.sv
addr_decoder.sv
misc_regs.sv
flash_reload.sv
soc_lite_top.sv
tb_soc_lite.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_soc_lite -f soc_lite.f -o sim_soc_lite

./obj_dir/sim_soc_lite > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
exit 0
